//--- design/meter_pkg.sv
/*
  meter control package
  bus widths, spi frame layout, register map, output modes and
  bit positions of the 29-bit conditioning bus
*/

package meter_pkg;

  ////////////////////////////////////////////////////////////
  // widths

  // conditioning bus, 4x4 mux lines + 8 monitor + 5 singles
  localparam int cond_w = 29;
  localparam int data_w = 32;
  localparam int addr_w = 7;

  // command byte is write flag then address
  localparam int cmd_w   = addr_w + 1;
  localparam int frame_w = cmd_w + data_w;

  ////////////////////////////////////////////////////////////
  // register map

  typedef enum logic [addr_w-1:0] {
    reg_led     = 7'd0,
    reg_spi_mux = 7'd1,
    reg_mode    = 7'd2,
    reg_direct  = 7'd3
  } reg_addr_t;

  // output modes, 5..7 unused and act as zeros
  typedef enum logic [2:0] {
    mode_zeros  = 3'd0,
    mode_ones   = 3'd1,
    mode_count  = 3'd2,
    mode_direct = 3'd3,
    mode_blink  = 3'd4
  } mode_t;

  // second chip select routing, other values mean none
  typedef enum logic [7:0] {
    route_none = 8'd0,
    route_4094 = 8'd1
  } route_t;

  ////////////////////////////////////////////////////////////
  // conditioning bus bit positions

  localparam int bit_azmux_lo      = 0;
  localparam int bit_himux_lo      = 4;
  localparam int bit_himux2_lo     = 8;
  localparam int bit_pc_sw         = 12;
  localparam int bit_led           = 13;
  localparam int bit_mon_lo        = 14;
  localparam int bit_adc_sw_lo     = 22;
  localparam int bit_cmpr_latch    = 26;
  localparam int bit_meas_complete = 27;
  localparam int bit_spi_int       = 28;

endpackage

//--- design/spi_port.sv
`timescale 1ns/10ps

/*
  spi port
  samples the mcu spi lines on clk, shifts in 40-bit frames, issues
  register writes, shifts readback out on miso and routes the second
  chip select through to the 4094 chain
*/

module spi_port
  import meter_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              spi_clk,
  input  logic              spi_cs,
  input  logic              spi_cs2,
  input  logic              spi_mosi,
  input  logic              sr_ret,
  input  route_t            spi_route,
  input  logic [data_w-1:0] rd_data,
  output logic              spi_miso,
  output logic              sr_clk,
  output logic              sr_data,
  output logic              sr_strobe,
  output logic              wr_en,
  output reg_addr_t         wr_addr,
  output reg_addr_t         rd_addr,
  output logic [data_w-1:0] wr_data
);

  // room to count one bit past a full frame
  localparam int cnt_w = $clog2(frame_w + 2);

  logic [1:0]         sck_sync;
  logic [1:0]         cs_sync;
  logic [1:0]         mosi_sync;
  logic               sck_d;
  logic               cs_d;
  logic               sck_rise;
  logic               sck_fall;
  logic               cs_fall;
  logic               cs_rise;
  logic               in_frame;
  logic               frame_ok;
  logic [cnt_w-1:0]   bit_cnt;
  logic [frame_w-1:0] shift_in;
  logic [cmd_w-1:0]   cmd_byte;
  logic               load_q;
  logic [data_w-1:0]  out_shift;
  logic               cs2_active;

  ////////////////////////////////////////////////////////////
  // two-flop synchronizers and edge detect

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_sync  <= '0;
      mosi_sync <= '0;
      sck_d     <= 1'b0;
      // chip select idles high
      cs_sync   <= '1;
      cs_d      <= 1'b1;
    end
    else
    begin
      sck_sync  <= {sck_sync[0], spi_clk};
      cs_sync   <= {cs_sync[0], spi_cs};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sck_d     <= sck_sync[1];
      cs_d      <= cs_sync[1];
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_d;
  assign sck_fall = ~sck_sync[1] & sck_d;
  assign cs_fall  = ~cs_sync[1] & cs_d;
  assign cs_rise  = cs_sync[1] & ~cs_d;
  assign in_frame = ~cs_sync[1];

  // exactly 40 bits, short or long frames are dropped
  assign frame_ok = (bit_cnt == cnt_w'(frame_w));

  // byte just completed on this edge, msb first
  assign cmd_byte = {shift_in[cmd_w-2:0], mosi_sync[1]};

  ////////////////////////////////////////////////////////////
  // frame receive

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (cs_fall)
      bit_cnt <= '0;
    else if (in_frame && sck_rise && bit_cnt <= cnt_w'(frame_w))
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (in_frame && sck_rise)
      shift_in <= {shift_in[frame_w-2:0], mosi_sync[1]};
  end

  // latch read address at end of command byte, held to frame end
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      load_q <= 1'b0;
    else
      load_q <= in_frame && sck_rise && (bit_cnt == cnt_w'(cmd_w - 1))
                && !cmd_byte[cmd_w-1];
  end

  always_ff @(posedge clk)
  begin
    if (in_frame && sck_rise && bit_cnt == cnt_w'(cmd_w - 1))
      rd_addr <= reg_addr_t'(cmd_byte[addr_w-1:0]);
  end

  // write strobe once the frame closes, flag in frame bit 39
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_en <= 1'b0;
    else
      wr_en <= cs_rise & frame_ok & shift_in[frame_w-1];
  end

  always_ff @(posedge clk)
  begin
    if (cs_rise && frame_ok)
    begin
      wr_addr <= reg_addr_t'(shift_in[frame_w-2 -: addr_w]);
      wr_data <= shift_in[data_w-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // readback shifter

  // first data bit must stay up across the falling edge after
  // the command byte, so shifting starts from bit 9
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_shift <= '0;
    else if (cs_fall || cs_rise)
      out_shift <= '0;
    else if (load_q)
      out_shift <= rd_data;
    else if (in_frame && sck_fall && bit_cnt > cnt_w'(cmd_w))
      out_shift <= {out_shift[data_w-2:0], 1'b0};
  end

  ////////////////////////////////////////////////////////////
  // 4094 pass-through, straight from the pins

  assign cs2_active = (spi_route == route_4094) & ~spi_cs2;

  // strobe high lets the 4094 outputs follow while selected
  assign sr_strobe = cs2_active;
  assign sr_clk    = cs2_active & spi_clk;
  assign sr_data   = cs2_active & spi_mosi;
  assign spi_miso  = cs2_active ? sr_ret : out_shift[data_w-1];

endmodule

//--- design/reg_bank.sv
`timescale 1ns/10ps

/*
  register bank
  four mcu-writable control registers with address decode
  and combinational readback
*/

module reg_bank
  import meter_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_en,
  input  reg_addr_t         wr_addr,
  input  logic [data_w-1:0] wr_data,
  input  reg_addr_t         rd_addr,
  output logic [data_w-1:0] rd_data,
  output mode_t             mode,
  output logic [cond_w-1:0] direct,
  output route_t            spi_route
);

  // full 32-bit storage, upper bits read back as written
  logic [data_w-1:0] r_led;
  logic [data_w-1:0] r_spi_mux;
  logic [data_w-1:0] r_mode;
  logic [data_w-1:0] r_direct;

  ////////////////////////////////////////////////////////////
  // write decode

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      r_led     <= '0;
      r_spi_mux <= '0;
      r_mode    <= '0;
      r_direct  <= '0;
    end
    else if (wr_en)
    begin
      case (wr_addr)
        reg_led:     r_led     <= wr_data;
        reg_spi_mux: r_spi_mux <= wr_data;
        reg_mode:    r_mode    <= wr_data;
        reg_direct:  r_direct  <= wr_data;
        // unmapped addresses are ignored
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // readback

  always_comb
  begin
    case (rd_addr)
      reg_led:     rd_data = r_led;
      reg_spi_mux: rd_data = r_spi_mux;
      reg_mode:    rd_data = r_mode;
      reg_direct:  rd_data = r_direct;
      default:     rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // field views for the later stages

  // low 3 bits pick the mode
  assign mode      = mode_t'(r_mode[2:0]);
  assign direct    = r_direct[cond_w-1:0];
  // low byte picks the cs2 target
  assign spi_route = route_t'(r_spi_mux[7:0]);

endmodule

//--- design/pattern_gen.sv
`timescale 1ns/10ps

/*
  test pattern generator
  free-running count pattern, and a blink pattern that toggles
  the pre-charge switch and led over the direct value
*/

module pattern_gen
  import meter_pkg::*;
#(
  parameter int clk_freq = 20000000,
  parameter int blink_hz = 10
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [cond_w-1:0] direct,
  output logic [cond_w-1:0] count_pat,
  output logic [cond_w-1:0] blink_pat
);

  // divider terminal count, one toggle per terminal
  localparam int div_top = clk_freq / blink_hz;
  localparam int div_w   = $clog2(div_top + 1);

  logic [div_w-1:0] div_cnt;
  // bit 0 drives pc_sw, bit 1 drives led
  logic [1:0]       phase;

  ////////////////////////////////////////////////////////////
  // count pattern

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      count_pat <= '0;
    else
      count_pat <= count_pat + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // blink divider

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      phase   <= '0;
    end
    else if (div_cnt == div_w'(div_top))
    begin
      // restart and flip both lines together
      div_cnt <= '0;
      phase   <= ~phase;
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // direct value with the two blink bits overridden
  always_comb
  begin
    blink_pat            = direct;
    blink_pat[bit_pc_sw] = phase[0];
    blink_pat[bit_led]   = phase[1];
  end

endmodule

//--- design/output_select.sv
`timescale 1ns/10ps

/*
  output selector
  registers the conditioning bus source picked by the
  mode register, unused modes give all zeros
*/

module output_select
  import meter_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  mode_t             mode,
  input  logic [cond_w-1:0] direct,
  input  logic [cond_w-1:0] count_pat,
  input  logic [cond_w-1:0] blink_pat,
  output logic [cond_w-1:0] cond
);

  logic [cond_w-1:0] cond_next;

  ////////////////////////////////////////////////////////////
  // source mux

  always_comb
  begin
    case (mode)
      mode_zeros:  cond_next = '0;
      mode_ones:   cond_next = '1;
      mode_count:  cond_next = count_pat;
      mode_direct: cond_next = direct;
      mode_blink:  cond_next = blink_pat;
      // modes 5 to 7
      default:     cond_next = '0;
    endcase
  end

  // one register stage so the pins change cleanly on clk
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cond <= '0;
    else
      cond <= cond_next;
  end

endmodule

//--- design/meter_ctl_top.sv
`timescale 1ns/10ps

/*
  meter board control fpga top
  spi port, register bank, pattern generator and output
  selector, with the conditioning bus split onto board pins
*/

module meter_ctl_top
  import meter_pkg::*;
#(
  parameter int clk_freq = 20000000,
  parameter int blink_hz = 10
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       spi_clk,
  input  logic       spi_cs,
  input  logic       spi_cs2,
  input  logic       spi_mosi,
  input  logic       sr_ret,
  output logic       spi_miso,
  output logic       sr_clk,
  output logic       sr_data,
  output logic       sr_strobe,
  output logic [3:0] azmux,
  output logic [3:0] himux,
  output logic [3:0] himux2,
  output logic       pc_sw,
  output logic       led,
  output logic [7:0] mon,
  output logic [3:0] adc_sw,
  output logic       cmpr_latch,
  output logic       meas_complete,
  output logic       spi_int
);

  logic              wr_en;
  reg_addr_t         wr_addr;
  reg_addr_t         rd_addr;
  logic [data_w-1:0] wr_data;
  logic [data_w-1:0] rd_data;
  mode_t             mode;
  logic [cond_w-1:0] direct;
  route_t            spi_route;
  logic [cond_w-1:0] count_pat;
  logic [cond_w-1:0] blink_pat;
  logic [cond_w-1:0] cond;

  ////////////////////////////////////////////////////////////
  // stages

  spi_port spi_port_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .spi_clk   (spi_clk),
    .spi_cs    (spi_cs),
    .spi_cs2   (spi_cs2),
    .spi_mosi  (spi_mosi),
    .sr_ret    (sr_ret),
    .spi_route (spi_route),
    .rd_data   (rd_data),
    .spi_miso  (spi_miso),
    .sr_clk    (sr_clk),
    .sr_data   (sr_data),
    .sr_strobe (sr_strobe),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .rd_addr   (rd_addr),
    .wr_data   (wr_data)
  );

  reg_bank reg_bank_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .mode      (mode),
    .direct    (direct),
    .spi_route (spi_route)
  );

  pattern_gen #(
    .clk_freq (clk_freq),
    .blink_hz (blink_hz)
  ) pattern_gen_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .direct    (direct),
    .count_pat (count_pat),
    .blink_pat (blink_pat)
  );

  output_select output_select_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mode      (mode),
    .direct    (direct),
    .count_pat (count_pat),
    .blink_pat (blink_pat),
    .cond      (cond)
  );

  ////////////////////////////////////////////////////////////
  // conditioning bus to pins

  // mux groups are en, a2, a1, a0 from msb down
  assign azmux         = cond[bit_azmux_lo +: 4];
  assign himux         = cond[bit_himux_lo +: 4];
  assign himux2        = cond[bit_himux2_lo +: 4];
  assign pc_sw         = cond[bit_pc_sw];
  assign led           = cond[bit_led];
  assign mon           = cond[bit_mon_lo +: 8];
  assign adc_sw        = cond[bit_adc_sw_lo +: 4];
  assign cmpr_latch    = cond[bit_cmpr_latch];
  assign meas_complete = cond[bit_meas_complete];
  assign spi_int       = cond[bit_spi_int];

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/10ps

/*
  testbench clock and reset
  free-running clock and an active-low reset held for a few cycles
*/

module clk_gen
#(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 5
)
(
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
  end

  // half period each way
  always #(period_ns / 2) clk = ~clk;

  // release just after an edge, like the other inputs
  initial
  begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #5 rst_n = 1'b1;
  end

endmodule

//--- bench/tb_meter_ctl.sv
`timescale 1ns/10ps

/*
  meter control testbench
  table of spi writes, reads, routing and pattern tests applied
  to the top level, with per-test report and a cycle timeout
*/

module tb_meter_ctl
  import meter_pkg::*;
();

  localparam int clk_freq   = 80;
  localparam int blink_hz   = 10;
  // blink bits hold for about this many clk cycles
  localparam int blink_div  = clk_freq / blink_hz;
  localparam int drive_dly  = 5;
  localparam int half_sck   = 4;
  localparam int settle_cyc = 10;
  localparam int count_len  = 16;
  localparam int blink_len  = 40;

  typedef enum logic [1:0] {k_write, k_read, k_route, k_pattern} kind_t;

  typedef struct packed {
    kind_t             kind;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [data_w-1:0] exp_val;
  } entry_t;

  logic clk, rst_n;
  logic spi_clk, spi_cs, spi_cs2, spi_mosi, sr_ret;
  logic spi_miso, sr_clk, sr_data, sr_strobe;
  logic [3:0] azmux, himux, himux2, adc_sw;
  logic [7:0] mon;
  logic pc_sw, led, cmpr_latch, meas_complete, spi_int;

  entry_t test_tbl[$];
  int     seed;
  int     err_cnt     = 0;
  int     pass_cnt    = 0;
  int     fail_cnt    = 0;
  int     cycle_cnt   = 0;
  int     cycle_limit = 0;

  clk_gen #(.period_ns(40), .reset_cycles(5)) clk_gen_i (.clk(clk), .rst_n(rst_n));

  meter_ctl_top #(
    .clk_freq (clk_freq),
    .blink_hz (blink_hz)
  ) dut_i (
    .clk (clk), .rst_n (rst_n), .spi_clk (spi_clk), .spi_cs (spi_cs),
    .spi_cs2 (spi_cs2), .spi_mosi (spi_mosi), .sr_ret (sr_ret),
    .spi_miso (spi_miso), .sr_clk (sr_clk), .sr_data (sr_data),
    .sr_strobe (sr_strobe), .azmux (azmux), .himux (himux), .himux2 (himux2),
    .pc_sw (pc_sw), .led (led), .mon (mon), .adc_sw (adc_sw),
    .cmpr_latch (cmpr_latch), .meas_complete (meas_complete), .spi_int (spi_int)
  );

  ////////////////////////////////////////////////////////////
  // helpers

  // wait n edges, then step past the edge before driving
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #drive_dly;
  endtask

  // board pins packed back into bus order
  function automatic logic [cond_w-1:0] pins_bus();
    logic [cond_w-1:0] b;
    b = '0;
    b[bit_azmux_lo +: 4]    = azmux;
    b[bit_himux_lo +: 4]    = himux;
    b[bit_himux2_lo +: 4]   = himux2;
    b[bit_pc_sw]            = pc_sw;
    b[bit_led]              = led;
    b[bit_mon_lo +: 8]      = mon;
    b[bit_adc_sw_lo +: 4]   = adc_sw;
    b[bit_cmpr_latch]       = cmpr_latch;
    b[bit_meas_complete]    = meas_complete;
    b[bit_spi_int]          = spi_int;
    return b;
  endfunction

  function automatic string kind_name(input kind_t k);
    case (k)
      k_write:   return "write";
      k_read:    return "read";
      k_route:   return "route";
      default:   return "pattern";
    endcase
  endfunction

  task automatic check_data(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cond(input string name, input logic [cond_w-1:0] exp,
                            input logic [cond_w-1:0] act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // spi master, mode 0, one bit per 8 clk

  task automatic spi_frame(input logic [frame_w-1:0] frame,
                           output logic [data_w-1:0] miso_word);
    logic [frame_w-1:0] sh;
    int i;
    sh        = frame;
    miso_word = '0;
    spi_clk   = 1'b0;
    spi_cs    = 1'b0;
    tick(half_sck);
    for (i = 0; i < frame_w; i++)
    begin
      // change on falling, sample on rising
      spi_mosi = sh[frame_w-1];
      sh       = {sh[frame_w-2:0], 1'b0};
      tick(half_sck);
      if (i >= cmd_w)
        miso_word = {miso_word[data_w-2:0], spi_miso};
      spi_clk = 1'b1;
      tick(half_sck);
      spi_clk = 1'b0;
    end
    spi_mosi = 1'b0;
    tick(half_sck);
    spi_cs = 1'b1;
    tick(half_sck);
  endtask

  task automatic write_frame(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    logic [data_w-1:0] unused;
    spi_frame({1'b1, addr, data}, unused);
  endtask

  task automatic read_frame(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
    spi_frame({1'b0, addr, {data_w{1'b0}}}, data);
  endtask

  ////////////////////////////////////////////////////////////
  // behavior checks

  task automatic check_count();
    logic [cond_w-1:0] prev;
    logic [cond_w-1:0] cur;
    int n;
    prev = pins_bus();
    for (n = 0; n < count_len; n++)
    begin
      tick(1);
      cur = pins_bus();
      check_cond("cond", prev + 1'b1, cur);
      prev = cur;
    end
  endtask

  task automatic check_blink(input logic [cond_w-1:0] dir);
    logic [cond_w-1:0] mask;
    logic prev_lvl;
    int run;
    int toggles;
    int n;
    mask            = '0;
    mask[bit_pc_sw] = 1'b1;
    mask[bit_led]   = 1'b1;
    prev_lvl        = pc_sw;
    run             = 0;
    toggles         = 0;
    for (n = 0; n < blink_len; n++)
    begin
      check_cond("cond", dir & ~mask, pins_bus() & ~mask);
      check_bit("led", pc_sw, led);
      if (pc_sw === prev_lvl)
        run++;
      else
      begin
        // first run is cut short by the mode write
        if (toggles > 0 && run != blink_div && run != blink_div + 1)
        begin
          $display("blink level held %0d samples before %0t, expected %0d or %0d",
                   run, $time, blink_div, blink_div + 1);
          err_cnt++;
        end
        toggles++;
        run      = 1;
        prev_lvl = pc_sw;
      end
      tick(1);
    end
    if (toggles < 2)
    begin
      $display("blink bits toggled only %0d times in %0d samples", toggles, blink_len);
      err_cnt++;
    end
  endtask

  // walk clk, data and return through all combinations with cs2 low
  task automatic check_route(input logic active);
    logic [2:0] v;
    int j;
    spi_cs2 = 1'b0;
    for (j = 0; j < 8; j++)
    begin
      v        = j[2:0];
      spi_clk  = v[0];
      spi_mosi = v[1];
      sr_ret   = v[2];
      tick(1);
      check_bit("sr_strobe", active, sr_strobe);
      check_bit("sr_clk", active & v[0], sr_clk);
      check_bit("sr_data", active & v[1], sr_data);
      if (active)
        check_bit("spi_miso", v[2], spi_miso);
    end
    spi_cs2  = 1'b1;
    spi_clk  = 1'b0;
    spi_mosi = 1'b0;
    sr_ret   = 1'b0;
    tick(1);
    check_bit("sr_strobe", 1'b0, sr_strobe);
  endtask

  task automatic check_reset();
    int errs_before;
    errs_before = err_cnt;
    check_cond("cond", '0, pins_bus());
    check_bit("sr_strobe", 1'b0, sr_strobe);
    check_bit("spi_miso", 1'b0, spi_miso);
    if (err_cnt == errs_before)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test 0 reset state: %s", (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////
  // table

  task automatic add_entry(input kind_t kind, input logic [addr_w-1:0] addr,
                           input logic [data_w-1:0] data, input logic [data_w-1:0] exp_val);
    entry_t e;
    e.kind    = kind;
    e.addr    = addr;
    e.data    = data;
    e.exp_val = exp_val;
    test_tbl.push_back(e);
  endtask

  task automatic build_table();
    logic [data_w-1:0] r_led;
    logic [data_w-1:0] r_dir;
    logic [data_w-1:0] r_dir2;
    logic [data_w-1:0] r_junk;
    logic [data_w-1:0] ones;
    r_led  = $random(seed);
    r_dir  = $random(seed);
    r_dir2 = $random(seed);
    r_junk = $random(seed);
    ones   = {{(data_w-cond_w){1'b0}}, {cond_w{1'b1}}};
    // registers clear after reset
    add_entry(k_read, reg_led, '0, '0);
    add_entry(k_read, reg_spi_mux, '0, '0);
    add_entry(k_read, reg_mode, '0, '0);
    add_entry(k_read, reg_direct, '0, '0);
    // write and readback, pins stay low in mode zeros
    add_entry(k_write, reg_led, r_led, '0);
    add_entry(k_write, reg_direct, r_dir, '0);
    add_entry(k_read, reg_led, '0, r_led);
    add_entry(k_read, reg_direct, '0, r_dir);
    // unmapped address
    add_entry(k_read, 7'd9, '0, '0);
    add_entry(k_write, 7'd9, r_junk, '0);
    add_entry(k_read, reg_led, '0, r_led);
    add_entry(k_read, reg_direct, '0, r_dir);
    add_entry(k_read, reg_mode, '0, '0);
    add_entry(k_read, reg_spi_mux, '0, '0);
    // output modes
    add_entry(k_write, reg_mode, 32'd1, ones);
    add_entry(k_read, reg_mode, '0, 32'd1);
    add_entry(k_write, reg_mode, 32'h5a5a_5a03, r_dir & ones);
    add_entry(k_read, reg_mode, '0, 32'h5a5a_5a03);
    add_entry(k_write, reg_direct, r_dir2, r_dir2 & ones);
    add_entry(k_read, reg_direct, '0, r_dir2);
    // unused modes fall back to zeros, ones in between
    add_entry(k_write, reg_mode, 32'd1, ones);
    add_entry(k_write, reg_mode, 32'd5, '0);
    add_entry(k_write, reg_mode, 32'd1, ones);
    add_entry(k_write, reg_mode, 32'd6, '0);
    add_entry(k_write, reg_mode, 32'd1, ones);
    add_entry(k_write, reg_mode, 32'd7, '0);
    add_entry(k_write, reg_mode, 32'd1, ones);
    add_entry(k_write, reg_mode, 32'd0, '0);
    // running patterns, blink keeps the direct value
    add_entry(k_pattern, reg_mode, 32'd2, '0);
    add_entry(k_pattern, reg_mode, 32'd4, r_dir2 & ones);
    add_entry(k_write, reg_mode, 32'd0, '0);
    // 4094 routing, only target 1 passes through
    add_entry(k_route, reg_spi_mux, 32'd1, 32'd1);
    add_entry(k_read, reg_spi_mux, '0, 32'd1);
    add_entry(k_route, reg_spi_mux, 32'd2, 32'd0);
    add_entry(k_route, reg_spi_mux, 32'd0, 32'd0);
  endtask

  task automatic run_entry(input int idx, input entry_t e);
    logic [data_w-1:0] rd;
    int errs_before;
    errs_before = err_cnt;
    case (e.kind)
      k_write:
      begin
        write_frame(e.addr, e.data);
        tick(settle_cyc);
        check_cond("cond", e.exp_val[cond_w-1:0], pins_bus());
      end
      k_read:
      begin
        read_frame(e.addr, rd);
        check_data("rd_data", e.exp_val, rd);
      end
      k_route:
      begin
        write_frame(reg_spi_mux, e.data);
        tick(settle_cyc);
        check_route(e.exp_val[0]);
      end
      default:
      begin
        write_frame(reg_mode, e.data);
        tick(settle_cyc);
        if (e.data[2:0] == 3'd2)
          check_count();
        else
          check_blink(e.exp_val[cond_w-1:0]);
      end
    endcase
    if (err_cnt == errs_before)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test %0d %s addr %0d data %h: %s", idx, kind_name(e.kind), e.addr, e.data,
             (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////
  // run

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d clk cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    spi_clk  = 1'b0;
    spi_cs   = 1'b1;
    spi_cs2  = 1'b1;
    spi_mosi = 1'b0;
    sr_ret   = 1'b0;
    seed     = 80984;
    build_table();
    // a full frame plus settling is about 345 cycles
    cycle_limit = test_tbl.size() * 400 + 100;
    wait (rst_n === 1'b1);
    tick(1);
    check_reset();
    for (int idx = 0; idx < test_tbl.size(); idx++)
      run_entry(idx + 1, test_tbl[idx]);
    $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- src.f
design/meter_pkg.sv
design/spi_port.sv
design/reg_bank.sv
design/pattern_gen.sv
design/output_select.sv
design/meter_ctl_top.sv
bench/clk_gen.sv
bench/tb_meter_ctl.sv

//--- Makefile
# Verilator build and run of the meter control testbench

VERILATOR ?= verilator
TOP       ?= tb_meter_ctl
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "no pass result in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
